// File: design/usb_prot_pkg.sv
`default_nettype none

package usb_prot_pkg;

	// Frame sync sequence
	localparam logic [7:0] SYNC_HI = 8'h5E;
	localparam logic [7:0] SYNC_LO = 8'h4D;

	// CRC-8 with the CCITT polynomial
	localparam logic [7:0] CRC_POLY = 8'h07;
	localparam logic [7:0] CRC_INIT = 8'h00;

	localparam int BYTES_PER_WORD = 4;

	// Parser FSM encoding
	localparam logic [2:0] ST_HUNT = 3'd0;
	localparam logic [2:0] ST_SYNC = 3'd1;
	localparam logic [2:0] ST_HDR  = 3'd2;
	localparam logic [2:0] ST_DATA = 3'd3;
	localparam logic [2:0] ST_DCRC = 3'd4;

	// Index of the header CRC byte
	localparam logic [1:0] HDR_LAST = 2'd3;

	typedef logic [7:0]  byte_t;
	typedef logic [31:0] word_t;
	typedef logic [2:0]  be_cnt_t;
	typedef logic [15:0] len_t;

	// Header as filled byte by byte, or read as fields
	typedef union packed {
		byte_t [3:0] bytes;
		struct packed {
			byte_t addr;
			len_t  len;
			byte_t crc;
		} fields;
	} hdr_u;

	// One byte through the CRC with MSB first
	function automatic byte_t crc8_step(input byte_t crc, input byte_t dat);
		byte_t c;
		c = crc ^ dat;
		for (int i = 0; i < 8; i++)
		begin
			if (c[7])
				c = {c[6:0], 1'b0} ^ CRC_POLY;
			else
				c = {c[6:0], 1'b0};
		end
		return c;
	endfunction

endpackage

`default_nettype wire

// File: design/byte_serializer.sv
`default_nettype none

module byte_serializer
	import usb_prot_pkg::*;
(
	input  wire     clk
	,input  wire     rst_n

	,input  wire     op_valid_i
	,input  word_t   op_dat_i
	,input  be_cnt_t op_be_i
	,output logic    op_ready_o

	,output logic    byte_valid_o
	,output byte_t   byte_dat_o
);

	word_t   word_q;
	be_cnt_t cnt_q;
	logic    take;

	// Free now, or the last held byte leaves this cycle
	assign op_ready_o = (cnt_q <= be_cnt_t'(1));
	assign take       = op_valid_i && op_ready_o;

	assign byte_valid_o = (cnt_q != '0);
	assign byte_dat_o   = word_q[31:24];

	// Bytes still to send
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cnt_q <= '0;
		end
		else if (take)
		begin
			cnt_q <= op_be_i;
		end
		else if (cnt_q != '0)
		begin
			cnt_q <= cnt_q - 1'b1;
		end
	end

	// Top byte goes out, rest moves up
	always_ff @(posedge clk)
	begin
		if (take)
		begin
			word_q <= op_dat_i;
		end
		else if (cnt_q != '0)
		begin
			word_q <= {word_q[23:0], 8'h00};
		end
	end

	// Beat size must be 1 to 4 while offered
	a_be_range: assert property (
		@(posedge clk) disable iff (!rst_n)
		op_valid_i |-> (op_be_i >= be_cnt_t'(1) && op_be_i <= be_cnt_t'(BYTES_PER_WORD))
	);

endmodule

`default_nettype wire

// File: design/frame_parser.sv
`default_nettype none

module frame_parser
	import usb_prot_pkg::*;
(
	input  wire    clk
	,input  wire    rst_n

	,input  wire    byte_valid_i
	,input  byte_t  byte_dat_i

	,output logic   pl_valid_o
	,output byte_t  pl_dat_o
	,output logic   pl_last_o

	,output byte_t  dat_addr_o
	,output len_t   dat_len_o
	,output logic   trsmt_cmplt_o
	,output logic   dat_crc_err_o
	,output logic   hdr_crc_err_o
);

	logic [2:0] state_q;
	logic [1:0] idx_q;
	len_t       rem_q;
	byte_t      crc_q;
	hdr_u       hdr_q;
	hdr_u       hdr_nxt;
	logic       hdr_ok;

	// Header with the current byte shifted in
	always_comb
	begin
		hdr_nxt.bytes = {hdr_q.bytes[2:0], byte_dat_i};
	end

	// Running CRC covers sync, address and length
	assign hdr_ok = (hdr_nxt.fields.crc == crc_q);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state_q       <= ST_HUNT;
			idx_q         <= '0;
			rem_q         <= '0;
			crc_q         <= CRC_INIT;
			pl_valid_o    <= 1'b0;
			pl_last_o     <= 1'b0;
			trsmt_cmplt_o <= 1'b0;
			dat_crc_err_o <= 1'b0;
			hdr_crc_err_o <= 1'b0;
		end
		else
		begin
			pl_valid_o    <= 1'b0;
			pl_last_o     <= 1'b0;
			trsmt_cmplt_o <= 1'b0;
			dat_crc_err_o <= 1'b0;
			hdr_crc_err_o <= 1'b0;

			if (byte_valid_i)
			begin
				case (state_q)
					ST_HUNT:
					begin
						if (byte_dat_i == SYNC_HI)
						begin
							state_q <= ST_SYNC;
							crc_q   <= crc8_step(CRC_INIT, byte_dat_i);
						end
					end

					ST_SYNC:
					begin
						if (byte_dat_i == SYNC_LO)
						begin
							state_q <= ST_HDR;
							idx_q   <= '0;
							crc_q   <= crc8_step(crc_q, byte_dat_i);
						end
						else if (byte_dat_i == SYNC_HI)
						begin
							// Repeated 5E restarts the sync
							crc_q <= crc8_step(CRC_INIT, byte_dat_i);
						end
						else
						begin
							state_q <= ST_HUNT;
						end
					end

					ST_HDR:
					begin
						if (idx_q != HDR_LAST)
						begin
							idx_q <= idx_q + 1'b1;
							crc_q <= crc8_step(crc_q, byte_dat_i);
						end
						else if (hdr_ok)
						begin
							crc_q <= CRC_INIT;
							rem_q <= hdr_nxt.fields.len;
							// With no payload the CRC byte is next
							if (hdr_nxt.fields.len == '0)
								state_q <= ST_DCRC;
							else
								state_q <= ST_DATA;
						end
						else
						begin
							hdr_crc_err_o <= 1'b1;
							state_q       <= ST_HUNT;
						end
					end

					ST_DATA:
					begin
						pl_valid_o <= 1'b1;
						pl_last_o  <= (rem_q == len_t'(1));
						crc_q      <= crc8_step(crc_q, byte_dat_i);
						rem_q      <= rem_q - 1'b1;
						if (rem_q == len_t'(1))
							state_q <= ST_DCRC;
					end

					ST_DCRC:
					begin
						trsmt_cmplt_o <= 1'b1;
						dat_crc_err_o <= (byte_dat_i != crc_q);
						state_q       <= ST_HUNT;
					end

					default:
					begin
						state_q <= ST_HUNT;
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (byte_valid_i && state_q == ST_HDR)
			hdr_q <= hdr_nxt;
		if (byte_valid_i && state_q == ST_DATA)
			pl_dat_o <= byte_dat_i;
		// Frame info only from a good header
		if (byte_valid_i && state_q == ST_HDR && idx_q == HDR_LAST && hdr_ok)
		begin
			dat_addr_o <= hdr_nxt.fields.addr;
			dat_len_o  <= hdr_nxt.fields.len;
		end
	end

	a_pl_after_data: assert property (
		@(posedge clk) disable iff (!rst_n)
		pl_valid_o |-> $past(byte_valid_i && state_q == ST_DATA)
	);

endmodule

`default_nettype wire

// File: design/word_packer.sv
`default_nettype none

module word_packer
	import usb_prot_pkg::*;
(
	input  wire     clk
	,input  wire     rst_n

	,input  wire     pl_valid_i
	,input  byte_t   pl_dat_i
	,input  wire     pl_last_i

	,output logic    dat_en_o
	,output word_t   dat_o
	,output be_cnt_t dat_be_o
);

	word_t   word_q;
	word_t   word_nxt;
	be_cnt_t cnt_q;
	logic    flush;

	// Place the byte below those already held
	always_comb
	begin
		if (cnt_q == '0)
		begin
			word_nxt = {pl_dat_i, 24'h000000};
		end
		else
		begin
			word_nxt = word_q;
			word_nxt[(BYTES_PER_WORD - 1 - int'(cnt_q)) * 8 +: 8] = pl_dat_i;
		end
	end

	// Word full or frame ended
	assign flush = pl_valid_i &&
		(pl_last_i || cnt_q == be_cnt_t'(BYTES_PER_WORD - 1));

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cnt_q    <= '0;
			dat_en_o <= 1'b0;
			dat_be_o <= '0;
		end
		else
		begin
			dat_en_o <= flush;
			if (flush)
			begin
				dat_be_o <= cnt_q + 1'b1;
				cnt_q    <= '0;
			end
			else if (pl_valid_i)
			begin
				cnt_q <= cnt_q + 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (pl_valid_i)
			word_q <= word_nxt;
		if (flush)
			dat_o <= word_nxt;
	end

	a_be_nonzero: assert property (
		@(posedge clk) disable iff (!rst_n)
		dat_en_o |-> dat_be_o != '0
	);

endmodule

`default_nettype wire

// File: design/usb_prot_decoder.sv
`default_nettype none

module usb_prot_decoder
	import usb_prot_pkg::*;
(
	input  wire     clk
	,input  wire     rst_n

	// Input word stream
	,input  wire     op_valid_i
	,input  word_t   op_dat_i
	,input  be_cnt_t op_be_i
	,output logic    op_ready_o

	// Repacked payload
	,output logic    dat_en_o
	,output word_t   dat_o
	,output be_cnt_t dat_be_o

	// Frame status
	,output byte_t   dat_addr_o
	,output len_t    dat_len_o
	,output logic    trsmt_cmplt_o
	,output logic    dat_crc_err_o
	,output logic    hdr_crc_err_o
);

	logic  byte_valid;
	byte_t byte_dat;
	logic  pl_valid;
	byte_t pl_dat;
	logic  pl_last;

	byte_serializer i_byte_serializer (
		.clk           (clk)
		,.rst_n         (rst_n)
		,.op_valid_i    (op_valid_i)
		,.op_dat_i      (op_dat_i)
		,.op_be_i       (op_be_i)
		,.op_ready_o    (op_ready_o)
		,.byte_valid_o  (byte_valid)
		,.byte_dat_o    (byte_dat)
	);

	frame_parser i_frame_parser (
		.clk            (clk)
		,.rst_n          (rst_n)
		,.byte_valid_i   (byte_valid)
		,.byte_dat_i     (byte_dat)
		,.pl_valid_o     (pl_valid)
		,.pl_dat_o       (pl_dat)
		,.pl_last_o      (pl_last)
		,.dat_addr_o     (dat_addr_o)
		,.dat_len_o      (dat_len_o)
		,.trsmt_cmplt_o  (trsmt_cmplt_o)
		,.dat_crc_err_o  (dat_crc_err_o)
		,.hdr_crc_err_o  (hdr_crc_err_o)
	);

	word_packer i_word_packer (
		.clk         (clk)
		,.rst_n       (rst_n)
		,.pl_valid_i  (pl_valid)
		,.pl_dat_i    (pl_dat)
		,.pl_last_i   (pl_last)
		,.dat_en_o    (dat_en_o)
		,.dat_o       (dat_o)
		,.dat_be_o    (dat_be_o)
	);

endmodule

`default_nettype wire

// File: tests/tb_usb_prot_ref.svh
`ifndef TB_USB_PROT_REF_SVH
`define TB_USB_PROT_REF_SVH

// Fibonacci LFSR with taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic int unsigned rand_bits(input int n);
	int unsigned v;
	v = 0;
	for (int i = 0; i < n; i++)
	begin
		lfsr_q = lfsr_next(lfsr_q);
		v = (v << 1) | lfsr_q[0];
	end
	return v;
endfunction

// Bit serial CRC-8 taking data MSB first
function automatic byte_t crc8_ref(input byte_t crc, input byte_t dat);
	byte_t c;
	logic  fb;
	c = crc;
	for (int i = 7; i >= 0; i--)
	begin
		fb = c[7] ^ dat[i];
		c = {c[6:0], 1'b0};
		if (fb)
			c = c ^ CRC_POLY;
	end
	return c;
endfunction

// Any byte except the first sync byte
function automatic byte_t filler_byte();
	byte_t b;
	b = byte_t'(rand_bits(8));
	return (b == SYNC_HI) ? 8'h00 : b;
endfunction

// Mode 0 adds a lone 5E, mode 1 a 5E just before the frame
task automatic add_garbage(input int mode);
	int n;
	n = rand_bits(2);
	for (int i = 0; i < n; i++)
		stim_q.push_back(filler_byte());
	if (mode == 0)
	begin
		stim_q.push_back(SYNC_HI);
		stim_q.push_back(8'hA7);
	end
	else if (mode == 1)
	begin
		stim_q.push_back(SYNC_HI);
	end
endtask

task automatic add_frame(input int len, input bit bad_hdr, input bit bad_dat);
	byte_t hb [5];
	byte_t pl [$];
	byte_t crc;
	word_t w;
	hb[0] = SYNC_HI;
	hb[1] = SYNC_LO;
	hb[2] = byte_t'(rand_bits(8));
	hb[3] = byte_t'(len >> 8);
	hb[4] = byte_t'(len);
	crc = CRC_INIT;
	for (int i = 0; i < 5; i++)
	begin
		stim_q.push_back(hb[i]);
		crc = crc8_ref(crc, hb[i]);
	end
	stim_q.push_back(bad_hdr ? crc ^ 8'h01 : crc);
	crc = CRC_INIT;
	for (int i = 0; i < len; i++)
	begin
		pl.push_back(bad_hdr ? filler_byte() : byte_t'(rand_bits(8)));
		stim_q.push_back(pl[i]);
		crc = crc8_ref(crc, pl[i]);
	end
	if (bad_hdr)
	begin
		// Rejected frame body is hunted through
		stim_q.push_back(filler_byte());
	end
	else
	begin
		stim_q.push_back(bad_dat ? crc ^ 8'h01 : crc);
		for (int i = 0; i < len; i += 4)
		begin
			w = '0;
			for (int k = 0; k < 4 && i + k < len; k++)
				w[31 - 8 * k -: 8] = pl[i + k];
			exp_word_q.push_back(w);
			exp_be_q.push_back(be_cnt_t'((len - i > 4) ? 4 : len - i));
			words_total++;
		end
	end
	ev_hdr_q.push_back(bad_hdr);
	ev_crc_q.push_back(bad_dat && !bad_hdr);
	ev_addr_q.push_back(hb[2]);
	ev_len_q.push_back(len_t'(len));
	ev_words_q.push_back(words_total);
endtask

task automatic build_stream(input int frames);
	int  len;
	int  r;
	int  mode;
	bit  bad_hdr;
	bit  bad_dat;
	for (int f = 0; f < frames; f++)
	begin
		mode = rand_bits(2);
		if (f == 0)
			mode = 0;
		if (f == 3)
			mode = 1;
		add_garbage(mode);
		r = rand_bits(3);
		len = (f == 1) ? 0 : rand_bits(5) % 21;
		bad_hdr = (f == 2) || (f > 4 && r == 0);
		bad_dat = (f == 4) || (f > 4 && r == 1);
		add_frame(len, bad_hdr, bad_dat);
	end
	add_garbage(2);
endtask

`endif

// File: tests/tb_usb_prot_decoder.sv
`default_nettype none

module tb_usb_prot_decoder
	import usb_prot_pkg::*;
();

	logic    clk;
	logic    rst_n;
	logic    op_valid_i;
	word_t   op_dat_i;
	be_cnt_t op_be_i;
	logic    op_ready_o;
	logic    dat_en_o;
	word_t   dat_o;
	be_cnt_t dat_be_o;
	byte_t   dat_addr_o;
	len_t    dat_len_o;
	logic    trsmt_cmplt_o;
	logic    dat_crc_err_o;
	logic    hdr_crc_err_o;

	logic [31:0] lfsr_q;
	byte_t   stim_q [$];
	word_t   exp_word_q [$];
	be_cnt_t exp_be_q [$];
	bit      ev_hdr_q [$];
	bit      ev_crc_q [$];
	byte_t   ev_addr_q [$];
	len_t    ev_len_q [$];
	int      ev_words_q [$];
	int      words_total;
	int      words_seen;
	int      cycles;
	int      limit;

	`include "tb_usb_prot_ref.svh"

	usb_prot_decoder i_usb_prot_decoder (
		.clk            (clk)
		,.rst_n          (rst_n)
		,.op_valid_i     (op_valid_i)
		,.op_dat_i       (op_dat_i)
		,.op_be_i        (op_be_i)
		,.op_ready_o     (op_ready_o)
		,.dat_en_o       (dat_en_o)
		,.dat_o          (dat_o)
		,.dat_be_o       (dat_be_o)
		,.dat_addr_o     (dat_addr_o)
		,.dat_len_o      (dat_len_o)
		,.trsmt_cmplt_o  (trsmt_cmplt_o)
		,.dat_crc_err_o  (dat_crc_err_o)
		,.hdr_crc_err_o  (hdr_crc_err_o)
	);

	always
	begin
		#50 clk = ~clk;
	end

	task automatic stop_failed();
		$display("TEST FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic report_error(input string msg);
		$display("ERROR at time %0t: %s", $time, msg);
		stop_failed();
	endtask

	task automatic compare_word(input word_t got, input word_t exp);
		if (got !== exp)
		begin
			$display("[FAIL] %0t: dat_o is %h, expected %h", $time, got, exp);
			stop_failed();
		end
	endtask

	task automatic verify_be(input be_cnt_t got, input be_cnt_t exp);
		if (got !== exp)
		begin
			$display("[FAIL] %0t: dat_be_o is %0d, expected %0d", $time, got, exp);
			stop_failed();
		end
	endtask

	task automatic expect_addr(input byte_t got, input byte_t exp);
		if (got !== exp)
		begin
			$display("[FAIL] %0t: dat_addr_o is %h, expected %h", $time, got, exp);
			stop_failed();
		end
	endtask

	task automatic confirm_len(input len_t got, input len_t exp);
		if (got !== exp)
		begin
			$display("[FAIL] %0t: dat_len_o is %0d, expected %0d", $time, got, exp);
			stop_failed();
		end
	endtask

	// Order is completion, data CRC error, header CRC error
	task automatic check_flags(input logic [2:0] exp);
		if ({trsmt_cmplt_o, dat_crc_err_o, hdr_crc_err_o} !== exp)
		begin
			$display("[FAIL] %0t: status flags are %b, expected %b", $time,
				{trsmt_cmplt_o, dat_crc_err_o, hdr_crc_err_o}, exp);
			stop_failed();
		end
	endtask

	task automatic check_frame_end();
		bit    hdr_bad;
		bit    dat_bad;
		byte_t addr;
		len_t  len;
		int    words;
		if (ev_hdr_q.size() == 0)
		begin
			report_error("frame status pulsed with no frame expected");
		end
		else
		begin
			hdr_bad = ev_hdr_q.pop_front();
			dat_bad = ev_crc_q.pop_front();
			addr = ev_addr_q.pop_front();
			len = ev_len_q.pop_front();
			words = ev_words_q.pop_front();
			check_flags({!hdr_bad, dat_bad, hdr_bad});
			if (words_seen != words)
				report_error("frame ended with the wrong number of output words");
			if (!hdr_bad)
			begin
				expect_addr(dat_addr_o, addr);
				confirm_len(dat_len_o, len);
			end
		end
	endtask

	// Outputs are sampled mid cycle
	always @(negedge clk)
	begin
		if (rst_n)
		begin
			if (dat_en_o)
			begin
				if (exp_word_q.size() == 0)
				begin
					report_error("dat_en_o pulsed with no word expected");
				end
				else
				begin
					compare_word(dat_o, exp_word_q.pop_front());
					verify_be(dat_be_o, exp_be_q.pop_front());
					words_seen++;
				end
			end
			if (trsmt_cmplt_o || hdr_crc_err_o || dat_crc_err_o)
				check_frame_end();
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (limit > 0 && cycles >= limit)
			report_error("run timed out before all expected outputs appeared");
	end

	initial
	begin
		int    n;
		word_t w;
		clk = 1'b0;
		rst_n = 1'b0;
		op_valid_i = 1'b0;
		op_dat_i = '0;
		op_be_i = be_cnt_t'(1);
		lfsr_q = 32'hcf3009a3;
		words_total = 0;
		words_seen = 0;
		cycles = 0;
		limit = 0;
		build_stream(30);
		limit = 40 * stim_q.size() + 200;

		repeat (8) @(posedge clk);
		check_flags(3'b000);
		if (dat_en_o !== 1'b0 || op_ready_o !== 1'b1)
			report_error("handshake outputs not idle during reset");
		@(negedge clk);
		rst_n = 1'b1;

		while (stim_q.size() != 0)
		begin
			if (rand_bits(2) == 0)
			begin
				op_valid_i = 1'b0;
				repeat (rand_bits(2) + 1) @(negedge clk);
			end
			n = rand_bits(2) + 1;
			if (n > stim_q.size())
				n = stim_q.size();
			w = '0;
			for (int k = 0; k < n; k++)
				w[31 - 8 * k -: 8] = stim_q.pop_front();
			op_valid_i = 1'b1;
			op_dat_i = w;
			op_be_i = be_cnt_t'(n);
			// Beat is taken on the next rising edge once ready
			while (!op_ready_o)
				@(negedge clk);
			@(negedge clk);
		end
		op_valid_i = 1'b0;

		while (exp_word_q.size() != 0 || ev_hdr_q.size() != 0)
			@(negedge clk);
		repeat (20) @(negedge clk);
		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+tests
design/usb_prot_pkg.sv
design/byte_serializer.sv
design/frame_parser.sv
design/word_packer.sv
design/usb_prot_decoder.sv
tests/tb_usb_prot_decoder.sv
